/* y86_fetch.f */
verilog/y86_fetch_pkg.sv
verilog/instr_mem.sv
verilog/mem_wait_timer.sv
verilog/fetch_decode.sv
verilog/fetch_control.sv
verilog/y86_fetch_unit.sv
tests/y86_fetch_unit_assert.sv
tests/y86_fetch_unit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = y86_fetch_unit_tb
FILELIST  = y86_fetch.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^>>> PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/y86_fetch_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module y86_fetch_unit_tb;

  localparam int MEM_BYTES   = 256;
  localparam int MEM_LATENCY = 2;
  localparam int NUM_RUNS    = 16;
  localparam int MAX_INSTR   = 64;
  // Each run loads memory once and fetches the program twice
  localparam int MAX_CYCLES  =
    NUM_RUNS * (MEM_BYTES + 2 * (MAX_INSTR * (MEM_LATENCY + 1) + 16)) + 200;

  logic                      clk;
  logic                      reset;
  logic                      start;
  y86_fetch_pkg::addr_t      start_pc;
  logic                      mem_we;
  y86_fetch_pkg::addr_t      mem_addr;
  y86_fetch_pkg::byte_t      mem_wdata;
  y86_fetch_pkg::fetch_rec_t fetch_out;
  logic                      fetch_valid;
  logic                      busy;
  y86_fetch_pkg::stat_e      stat;

  integer seed        = 57387;
  int     errors      = 0;
  int     checks      = 0;
  int     cycle_count = 0;

  y86_fetch_pkg::byte_t      mem_model [MEM_BYTES];         // Program image as loaded
  y86_fetch_pkg::fetch_rec_t exp_rec_q [$];
  y86_fetch_pkg::stat_e      exp_stat_q [$];

  y86_fetch_unit #(.MEM_BYTES(MEM_BYTES), .MEM_LATENCY(MEM_LATENCY)) y86_fetch_unit_inst (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .start_pc    (start_pc),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .fetch_out   (fetch_out),
    .fetch_valid (fetch_valid),
    .busy        (busy),
    .stat        (stat)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles, fetch never finished", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic y86_fetch_pkg::byte_t model_byte(input y86_fetch_pkg::addr_t a);
    if (a < y86_fetch_pkg::addr_t'(MEM_BYTES))
    begin
      return mem_model[a[7:0]];
    end
    return 8'h00;                                           // Past the end reads zero
  endfunction

  function automatic int instr_len(input logic [3:0] ic);
    case (ic)
      4'h2, 4'h6, 4'hA, 4'hB: return 2;
      4'h3, 4'h4, 4'h5:       return 10;
      4'h7, 4'h8:             return 9;
      default:                return 1;                     // Also bad icodes
    endcase
  endfunction

  function automatic bit has_regs(input logic [3:0] ic);
    return (ic >= 4'h2 && ic <= 4'h6) || ic == 4'hA || ic == 4'hB;
  endfunction

  function automatic bit instr_valid(input y86_fetch_pkg::byte_t b);
    case (b[7:4])
      4'h2, 4'h7:             return b[3:0] <= 4'h6;
      4'h6:                   return b[3:0] <= 4'h3;
      4'hC, 4'hD, 4'hE, 4'hF: return 1'b0;
      default:                return b[3:0] == 4'h0;
    endcase
  endfunction

  function automatic y86_fetch_pkg::byte_t random_opcode(input bit jumps);
    case (rand_below(jumps ? 10 : 8))
      0:       return 8'h10;
      1:       return {4'h2, 4'(rand_below(7))};
      2:       return 8'h30;
      3:       return 8'h40;
      4:       return 8'h50;
      5:       return {4'h6, 4'(rand_below(4))};
      6:       return 8'hA0;
      7:       return 8'hB0;
      8:       return {4'h7, 4'(rand_below(7))};
      default: return 8'h80;
    endcase
  endfunction

  // Writes one instruction into the image and moves pc along the predicted path
  task automatic emit_instr(inout y86_fetch_pkg::addr_t pc, input y86_fetch_pkg::byte_t b0,
                            input y86_fetch_pkg::addr_t jump_to);
    int                   len;
    int                   voff;
    logic [63:0]          c;
    y86_fetch_pkg::byte_t b;
    len  = instr_len(b0[7:4]);
    voff = (len == 10) ? 2 : 1;
    c    = {$random(seed), $random(seed)};
    if (b0[7:4] == 4'h7 || b0[7:4] == 4'h8)
    begin
      c = jump_to;
    end
    for (int k = 0; k < len; k++)
    begin
      if (k == 0)
        b = b0;
      else if (k < voff)
        b = 8'($random(seed));                              // Register byte
      else
        b = c[8*(k-voff) +: 8];
      if (pc + y86_fetch_pkg::addr_t'(k) < y86_fetch_pkg::addr_t'(MEM_BYTES))
        mem_model[pc[7:0] + 8'(k)] = b;
    end
    pc = (b0[7:4] == 4'h7 || b0[7:4] == 4'h8) ? c : pc + y86_fetch_pkg::addr_t'(len);
  endtask

  task automatic build_program(input y86_fetch_pkg::addr_t base, input int term, input bit jumps);
    y86_fetch_pkg::addr_t pc;
    y86_fetch_pkg::byte_t b;
    int                   n;
    for (int a = 0; a < MEM_BYTES; a++)
      mem_model[a] = 8'($random(seed));                     // Filler that jumps skip over
    pc = base;
    n  = 0;
    while (n < 40 && pc + 64'd40 <= y86_fetch_pkg::addr_t'(MEM_BYTES))
    begin
      emit_instr(pc, random_opcode(jumps), pc + y86_fetch_pkg::addr_t'(9 + rand_below(8)));
      n++;
    end
    case (term)
      0: emit_instr(pc, 8'h00, '0);
      1: emit_instr(pc, 8'h90, '0);
      2:
      begin
        b = 8'($random(seed));
        while (instr_valid(b))
          b = 8'($random(seed));
        emit_instr(pc, b, pc + 64'd9);
      end
      default:
      begin
        // Jump near the end so the irmovq crosses the last address
        emit_instr(pc, {4'h7, 4'(rand_below(7))}, y86_fetch_pkg::addr_t'(247 + rand_below(9)));
        emit_instr(pc, 8'h30, '0);
      end
    endcase
  endtask

  // Walks the image from base and queues what fetch should report
  task automatic model_run(input y86_fetch_pkg::addr_t base);
    y86_fetch_pkg::fetch_rec_t r;
    y86_fetch_pkg::stat_e      s;
    y86_fetch_pkg::addr_t      pc;
    y86_fetch_pkg::byte_t      b0;
    y86_fetch_pkg::byte_t      b1;
    int                        len;
    int                        voff;
    bit                        done;
    pc   = base;
    done = 1'b0;
    while (!done && exp_rec_q.size() < MAX_INSTR)
    begin
      b0      = model_byte(pc);
      b1      = model_byte(pc + 64'd1);
      len     = instr_len(b0[7:4]);
      voff    = (len == 10) ? 2 : 1;
      r.pc    = pc;
      r.icode = y86_fetch_pkg::icode_e'(b0[7:4]);
      r.ifun  = b0[3:0];
      r.ra    = has_regs(b0[7:4]) ? b1[7:4] : 4'hF;
      r.rb    = has_regs(b0[7:4]) ? b1[3:0] : 4'hF;
      r.valc  = '0;
      r.valp  = pc + y86_fetch_pkg::addr_t'(len);
      if (len >= 9)
      begin
        for (int k = 0; k < 8; k++)
          r.valc[8*k +: 8] = model_byte(pc + y86_fetch_pkg::addr_t'(voff + k));
      end
      if (r.valp > y86_fetch_pkg::addr_t'(MEM_BYTES))
        s = y86_fetch_pkg::STAT_ADR;
      else if (!instr_valid(b0))
        s = y86_fetch_pkg::STAT_INS;
      else if (b0[7:4] == 4'h0)
        s = y86_fetch_pkg::STAT_HLT;
      else
        s = y86_fetch_pkg::STAT_AOK;
      exp_rec_q.push_back(r);
      exp_stat_q.push_back(s);
      done = (s != y86_fetch_pkg::STAT_AOK) || (b0[7:4] == 4'h9);
      pc   = (b0[7:4] == 4'h7 || b0[7:4] == 4'h8) ? r.valc : r.valp;
    end
  endtask

  task automatic load_memory();
    for (int a = 0; a < MEM_BYTES; a++)
    begin
      mem_we    = 1'b1;
      mem_addr  = y86_fetch_pkg::addr_t'(a);
      mem_wdata = mem_model[a];
      @(negedge clk);
    end
    mem_we = 1'b0;
  endtask

  task automatic run_program(input y86_fetch_pkg::addr_t base);
    y86_fetch_pkg::fetch_rec_t exp_rec;
    y86_fetch_pkg::stat_e      exp_stat;
    model_run(base);
    start    = 1'b1;
    start_pc = base;
    @(negedge clk);
    start = 1'b0;
    while (exp_rec_q.size() > 0)
    begin
      @(negedge clk);
      if (fetch_valid)
      begin
        exp_rec  = exp_rec_q.pop_front();
        exp_stat = exp_stat_q.pop_front();
        check_value("fetch_out.pc", fetch_out.pc, exp_rec.pc);
        check_value("fetch_out.icode", 64'(fetch_out.icode), 64'(exp_rec.icode));
        check_value("fetch_out.ifun", 64'(fetch_out.ifun), 64'(exp_rec.ifun));
        check_value("fetch_out.ra", 64'(fetch_out.ra), 64'(exp_rec.ra));
        check_value("fetch_out.rb", 64'(fetch_out.rb), 64'(exp_rec.rb));
        check_value("fetch_out.valc", fetch_out.valc, exp_rec.valc);
        check_value("fetch_out.valp", fetch_out.valp, exp_rec.valp);
        check_value("stat", 64'(stat), 64'(exp_stat));
        check_value("busy", 64'(busy), 64'(exp_rec_q.size() > 0));
      end
      // Stray writes and starts while busy
      mem_we    = busy && (rand_below(2) == 0);
      mem_addr  = y86_fetch_pkg::addr_t'(rand_below(MEM_BYTES));
      mem_wdata = 8'($random(seed));
      start     = busy && (rand_below(4) == 0);
      start_pc  = y86_fetch_pkg::addr_t'(rand_below(MEM_BYTES));
    end
    mem_we = 1'b0;
    start  = 1'b0;
    repeat (2 * (MEM_LATENCY + 1) + 4)
    begin
      @(negedge clk);
      check_value("fetch_valid", 64'(fetch_valid), 64'd0);  // Quiet until the next start
      check_value("busy", 64'(busy), 64'd0);
      check_value("stat", 64'(stat), 64'(exp_stat));       // Stop reason is held
    end
  endtask

  initial
  begin
    y86_fetch_pkg::addr_t base;
    reset     = 1'b1;
    start     = 1'b0;
    start_pc  = '0;
    mem_we    = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("busy", 64'(busy), 64'd0);
    check_value("fetch_valid", 64'(fetch_valid), 64'd0);
    check_value("stat", 64'(stat), 64'(y86_fetch_pkg::STAT_AOK));
    for (int r = 0; r < NUM_RUNS; r++)
    begin
      base = y86_fetch_pkg::addr_t'(rand_below(32));
      build_program(base, r % 4, r[2]);                     // halt, ret, bad opcode, ADR
      load_memory();
      run_program(base);
      run_program(base);                                    // Restart from STOPPED, same image
    end
    $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycle_count);
    if (errors == 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/y86_fetch_unit_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_control_assert (
  input wire clk,
  input wire reset,
  input wire fetch_valid,
  input wire read_strobe,
  input wire busy
);

  valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
    fetch_valid |=> !fetch_valid)
    else $error("fetch_valid held longer than one cycle");

  strobe_in_busy: assert property (@(posedge clk) disable iff (reset)
    read_strobe |-> busy)
    else $error("read_strobe outside busy");

  // Stop is only seen with the last record
  busy_drop: assert property (@(posedge clk) disable iff (reset)
    $fell(busy) |-> fetch_valid)
    else $error("busy fell without fetch_valid");

endmodule

bind fetch_control fetch_control_assert fetch_control_assert_inst (
  .clk         (clk),
  .reset       (reset),
  .fetch_valid (fetch_valid),
  .read_strobe (read_strobe),
  .busy        (busy)
);

`default_nettype wire

/* verilog/y86_fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module y86_fetch_unit #(
  parameter int MEM_BYTES   = 1024,
  parameter int MEM_LATENCY = 2                     // At least 1
) (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       start,
  input  y86_fetch_pkg::addr_t      start_pc,
  input  wire                       mem_we,
  input  y86_fetch_pkg::addr_t      mem_addr,
  input  y86_fetch_pkg::byte_t      mem_wdata,
  output y86_fetch_pkg::fetch_rec_t fetch_out,
  output wire                       fetch_valid,
  output wire                       busy,
  output y86_fetch_pkg::stat_e      stat
);

  y86_fetch_pkg::addr_t          pc;
  wire                           read_strobe;
  wire                           mem_done;
  y86_fetch_pkg::instr_window_t  window;
  y86_fetch_pkg::fetch_rec_t     dec_rec;
  y86_fetch_pkg::addr_t          next_pc;
  wire                           instr_ok;
  wire                           addr_ok;

  fetch_control fetch_control_inst (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .start_pc    (start_pc),
    .mem_done    (mem_done),
    .rec         (dec_rec),
    .next_pc     (next_pc),
    .instr_ok    (instr_ok),
    .addr_ok     (addr_ok),
    .pc          (pc),
    .read_strobe (read_strobe),
    .fetch_out   (fetch_out),
    .fetch_valid (fetch_valid),
    .busy        (busy),
    .stat        (stat)
  );

  mem_wait_timer #(.MEM_LATENCY(MEM_LATENCY)) mem_wait_timer_inst (
    .clk         (clk),
    .reset       (reset),
    .read_strobe (read_strobe),
    .mem_done    (mem_done)
  );

  instr_mem #(.MEM_BYTES(MEM_BYTES)) instr_mem_inst (
    .clk         (clk),
    .we          (mem_we && !busy),                 // Program loads only while idle
    .waddr       (mem_addr),
    .wdata       (mem_wdata),
    .read_strobe (read_strobe),
    .raddr       (pc),
    .window      (window)
  );

  fetch_decode #(.MEM_BYTES(MEM_BYTES)) fetch_decode_inst (
    .pc          (pc),
    .window      (window),
    .rec         (dec_rec),
    .next_pc     (next_pc),
    .instr_ok    (instr_ok),
    .addr_ok     (addr_ok)
  );

endmodule

`default_nettype wire

/* verilog/fetch_control.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_control (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       start,
  input  y86_fetch_pkg::addr_t      start_pc,
  input  wire                       mem_done,
  input  y86_fetch_pkg::fetch_rec_t rec,
  input  y86_fetch_pkg::addr_t      next_pc,
  input  wire                       instr_ok,
  input  wire                       addr_ok,
  output y86_fetch_pkg::addr_t      pc,
  output logic                      read_strobe,
  output y86_fetch_pkg::fetch_rec_t fetch_out,
  output logic                      fetch_valid,
  output wire                       busy,
  output y86_fetch_pkg::stat_e      stat
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,                                           // Read issued, waiting on memory
    STOPPED
  } state_e;

  state_e               state;
  y86_fetch_pkg::stat_e stat_next;
  logic                 stop;

  assign busy = (state == WAIT);

  // Status priority ADR > INS > HLT > AOK
  always_comb
  begin
    if (!addr_ok)
    begin
      stat_next = y86_fetch_pkg::STAT_ADR;
    end
    else if (!instr_ok)
    begin
      stat_next = y86_fetch_pkg::STAT_INS;
    end
    else if (rec.icode == y86_fetch_pkg::I_HALT)
    begin
      stat_next = y86_fetch_pkg::STAT_HLT;
    end
    else
    begin
      stat_next = y86_fetch_pkg::STAT_AOK;
    end
    // ret stops too since its target is unknown here
    stop = (stat_next != y86_fetch_pkg::STAT_AOK) || (rec.icode == y86_fetch_pkg::I_RET);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= IDLE;
      pc          <= '0;
      read_strobe <= 1'b0;
      fetch_valid <= 1'b0;
      stat        <= y86_fetch_pkg::STAT_AOK;
    end
    else
    begin
      read_strobe <= 1'b0;
      fetch_valid <= 1'b0;
      case (state)
        IDLE, STOPPED:
        begin
          if (start)
          begin
            state       <= WAIT;
            pc          <= start_pc;
            read_strobe <= 1'b1;
            stat        <= y86_fetch_pkg::STAT_AOK; // Old stop reason cleared
          end
        end
        WAIT:
        begin
          if (mem_done)
          begin
            fetch_valid <= 1'b1;
            stat        <= stat_next;
            if (stop)
            begin
              state <= STOPPED;                     // busy falls with the last fetch_valid
            end
            else
            begin
              pc          <= next_pc;
              read_strobe <= 1'b1;                  // Next read starts right away
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == WAIT) && mem_done)
    begin
      fetch_out <= rec;
    end
  end

endmodule

`default_nettype wire

/* verilog/fetch_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_decode #(
  parameter int MEM_BYTES = 1024
) (
  input  y86_fetch_pkg::addr_t         pc,
  input  y86_fetch_pkg::instr_window_t window,
  output y86_fetch_pkg::fetch_rec_t    rec,
  output y86_fetch_pkg::addr_t         next_pc,
  output logic                         instr_ok,
  output logic                         addr_ok
);

  localparam int TOP = y86_fetch_pkg::INSTR_BYTES * 8 - 1;

  logic [3:0]           icode_raw;
  logic [3:0]           ifun;
  logic [3:0]           len;
  logic                 has_regs;
  y86_fetch_pkg::word_t valc_b1;                    // Constant after the opcode byte
  y86_fetch_pkg::word_t valc_b2;                    // Constant after the register byte
  y86_fetch_pkg::word_t valc;
  y86_fetch_pkg::addr_t valp;
  logic [64:0]          end_addr;

  assign icode_raw = window[TOP -: 4];
  assign ifun      = window[TOP-4 -: 4];

  // Little-endian constants
  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      valc_b1[8*i +: 8] = window[TOP - 8*(i+1) -: 8];
      valc_b2[8*i +: 8] = window[TOP - 8*(i+2) -: 8];
    end
  end

  always_comb
  begin
    len      = 4'd1;
    has_regs = 1'b0;
    valc     = '0;
    instr_ok = 1'b1;
    case (icode_raw)
      y86_fetch_pkg::I_HALT, y86_fetch_pkg::I_NOP, y86_fetch_pkg::I_RET:
        instr_ok = (ifun == 4'h0);
      y86_fetch_pkg::I_CMOV:
      begin
        len      = 4'd2;
        has_regs = 1'b1;
        instr_ok = (ifun <= 4'h6);                  // rrmovq plus six conditions
      end
      y86_fetch_pkg::I_OP:
      begin
        len      = 4'd2;
        has_regs = 1'b1;
        instr_ok = (ifun <= 4'h3);
      end
      y86_fetch_pkg::I_PUSH, y86_fetch_pkg::I_POP:
      begin
        len      = 4'd2;
        has_regs = 1'b1;
        instr_ok = (ifun == 4'h0);
      end
      y86_fetch_pkg::I_IRMOV, y86_fetch_pkg::I_RMMOV, y86_fetch_pkg::I_MRMOV:
      begin
        len      = 4'd10;
        has_regs = 1'b1;
        valc     = valc_b2;
        instr_ok = (ifun == 4'h0);
      end
      y86_fetch_pkg::I_JXX:
      begin
        len      = 4'd9;
        valc     = valc_b1;
        instr_ok = (ifun <= 4'h6);
      end
      y86_fetch_pkg::I_CALL:
      begin
        len      = 4'd9;
        valc     = valc_b1;
        instr_ok = (ifun == 4'h0);
      end
      default: instr_ok = 1'b0;                     // icode C to F
    endcase
  end

  assign valp     = pc + y86_fetch_pkg::addr_t'(len);
  assign end_addr = {1'b0, pc} + 65'(len);          // Extra bit keeps a wrapped PC out of range
  assign addr_ok  = (end_addr <= 65'(MEM_BYTES));

  always_comb
  begin
    rec.pc    = pc;
    rec.icode = y86_fetch_pkg::icode_e'(icode_raw);
    rec.ifun  = ifun;
    rec.ra    = has_regs ? window[TOP-8 -: 4] : y86_fetch_pkg::REG_NONE;
    rec.rb    = has_regs ? window[TOP-12 -: 4] : y86_fetch_pkg::REG_NONE;
    rec.valc  = valc;
    rec.valp  = valp;
  end

  // Branches and calls are predicted taken
  assign next_pc = ((icode_raw == y86_fetch_pkg::I_JXX) || (icode_raw == y86_fetch_pkg::I_CALL))
                   ? valc : valp;

endmodule

`default_nettype wire

/* verilog/mem_wait_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_wait_timer #(
  parameter int MEM_LATENCY = 2
) (
  input  wire clk,
  input  wire reset,
  input  wire read_strobe,
  output wire mem_done
);

  localparam int CW = $clog2(MEM_LATENCY + 1);

  logic [CW-1:0] count;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      count <= '0;
    end
    else if (read_strobe)
    begin
      count <= CW'(MEM_LATENCY);                    // Restart on every read
    end
    else if (count != '0)
    begin
      count <= count - CW'(1);
    end
  end

  assign mem_done = (count == CW'(1));              // Last cycle of the wait

endmodule

`default_nettype wire

/* verilog/instr_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_mem #(
  parameter int MEM_BYTES = 1024
) (
  input  wire                          clk,
  input  wire                          we,
  input  y86_fetch_pkg::addr_t         waddr,
  input  y86_fetch_pkg::byte_t         wdata,
  input  wire                          read_strobe,
  input  y86_fetch_pkg::addr_t         raddr,
  output y86_fetch_pkg::instr_window_t window
);

  localparam int AW = (MEM_BYTES > 1) ? $clog2(MEM_BYTES) : 1;
  localparam int NB = y86_fetch_pkg::INSTR_BYTES;

  y86_fetch_pkg::byte_t mem [MEM_BYTES];

  // Out-of-range bytes read as zero
  function automatic y86_fetch_pkg::byte_t read_byte(input y86_fetch_pkg::addr_t a);
    if (a < y86_fetch_pkg::addr_t'(MEM_BYTES))
    begin
      return mem[a[AW-1:0]];
    end
    return '0;
  endfunction

  always_ff @(posedge clk)
  begin
    if (we && (waddr < y86_fetch_pkg::addr_t'(MEM_BYTES)))
    begin
      mem[waddr[AW-1:0]] <= wdata;                  // Writes past the end are dropped
    end
  end

  // Window is captured once per strobe and held for decode
  always_ff @(posedge clk)
  begin
    if (read_strobe)
    begin
      for (int i = 0; i < NB; i++)
      begin
        window[(NB-1-i)*8 +: 8] <= read_byte(raddr + y86_fetch_pkg::addr_t'(i));
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/y86_fetch_pkg.sv */
`default_nettype none

package y86_fetch_pkg;

  localparam int INSTR_BYTES = 10;       // Longest Y86-64 instruction

  typedef logic [63:0] addr_t;           // Byte address or PC
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  reg_id_t;         // F means no register
  typedef logic [63:0] word_t;           // Immediate or displacement

  localparam reg_id_t REG_NONE = 4'hF;

  // First byte at the PC sits in the top bits
  typedef logic [INSTR_BYTES*8-1:0] instr_window_t;

  typedef enum logic [3:0] {
    I_HALT  = 4'h0,
    I_NOP   = 4'h1,
    I_CMOV  = 4'h2,
    I_IRMOV = 4'h3,
    I_RMMOV = 4'h4,
    I_MRMOV = 4'h5,
    I_OP    = 4'h6,
    I_JXX   = 4'h7,
    I_CALL  = 4'h8,
    I_RET   = 4'h9,
    I_PUSH  = 4'hA,
    I_POP   = 4'hB
  } icode_e;

  typedef enum logic [1:0] {
    STAT_AOK = 2'd0,                     // Running, or stopped on ret
    STAT_HLT = 2'd1,
    STAT_ADR = 2'd2,                     // Instruction runs past memory end
    STAT_INS = 2'd3                      // Bad icode/ifun pair
  } stat_e;

  // One fetched instruction
  typedef struct packed {
    addr_t   pc;
    icode_e  icode;
    logic [3:0] ifun;
    reg_id_t ra;
    reg_id_t rb;
    word_t   valc;
    addr_t   valp;                       // Address of the following instruction
  } fetch_rec_t;

endpackage

`default_nettype wire
